// File: hw/pbch_pkg.sv
`default_nettype none

package pbch_pkg;

    // sample layout: imaginary in the upper half, real in the lower half
    localparam int SAMPLE_W = 32;
    localparam int FFT_LEN = 256;
    localparam int SC_W = 8;

    // cell identity, up to 1007
    localparam int NID_W = 10;

    // ibar_SSB candidates
    localparam int NUM_IBAR = 8;
    localparam int IBAR_W = 3;

    // one accumulator per candidate and rotation
    localparam int SEL_W = IBAR_W + 1;

    // pilot pairs in one PBCH symbol, every fourth subcarrier
    localparam int NUM_PILOTS = 64;
    localparam int PILOT_W = 6;
    localparam int STORE_STEPS = 2 * NUM_PILOTS;

    // Gold sequence, LFSR length and offset Nc
    localparam int GOLD_N = 31;
    localparam int GOLD_SKIP = 1600;
    localparam int GEN_CNT_W = 11;

    // magnitude of a correlation, two bits per pilot
    localparam int CORR_W = 8;
    localparam int ACC_MAX = 2 * NUM_PILOTS;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_STORE,
        GEN_DONE
    } gen_state_e;

    typedef enum logic [1:0] {
        DET_IDLE,
        DET_ACCUM,
        DET_SEARCH,
        DET_REPORT
    } det_state_e;

endpackage

`default_nettype wire

// File: hw/gold_seq_gen.sv
`timescale 1ns/100ps
`default_nettype none

module gold_seq_gen (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]     n_id_i,
    input  logic                           n_id_valid_i,
    input  logic                           load_i,
    input  logic                           step_i,
    output logic [pbch_pkg::NUM_IBAR-1:0]  c_bits_o
);
    import pbch_pkg::*;

    logic [NID_W-1:0]  n_id_q;
    logic [GOLD_N-1:0] x1_q;
    logic [GOLD_N-1:0] x2_q [NUM_IBAR];

    // c_init = 2^11 (ibar+1)(floor(N_id/4)+1) + 2^6 (ibar+1) + N_id mod 4
    function automatic logic [GOLD_N-1:0] c_init(input logic [IBAR_W-1:0] ibar,
                                                 input logic [NID_W-1:0] n_id);
        logic [GOLD_N-1:0] ibar_p1;
        logic [GOLD_N-1:0] group_p1;
        ibar_p1 = GOLD_N'(ibar) + 1'b1;
        group_p1 = GOLD_N'(n_id >> 2) + 1'b1;
        return ((ibar_p1 * group_p1) << 11) + (ibar_p1 << 6) + GOLD_N'(n_id[1:0]);
    endfunction

    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            n_id_q <= n_id_i;
        end
    end

    // bit 0 holds x(n), new bits enter at the top
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            x1_q <= GOLD_N'(1);
            for (int i = 0; i < NUM_IBAR; i++) begin
                x2_q[i] <= c_init(IBAR_W'(i), n_id_q);
            end
        end else if (step_i) begin
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[GOLD_N-1:1]};
            for (int i = 0; i < NUM_IBAR; i++) begin
                x2_q[i] <= {x2_q[i][3] ^ x2_q[i][2] ^ x2_q[i][1] ^ x2_q[i][0],
                            x2_q[i][GOLD_N-1:1]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            c_bits_o[i] = x1_q[0] ^ x2_q[i][0];
        end
    end

    // the controller loads and steps in separate states
    load_step_excl_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        !(load_i && step_i));

endmodule

`default_nettype wire

// File: hw/dmrs_store.sv
`timescale 1ns/100ps
`default_nettype none

module dmrs_store (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic                                wr_en_i,
    input  logic [pbch_pkg::PILOT_W-1:0]        wr_idx_i,
    input  logic                                wr_bit_sel_i,
    input  logic [pbch_pkg::NUM_IBAR-1:0]       wr_bits_i,
    input  logic [pbch_pkg::PILOT_W-1:0]        rd_idx_i,
    output logic [pbch_pkg::NUM_IBAR-1:0][1:0]  rd_pairs_o
);
    import pbch_pkg::*;

    // one word per pilot index, holding the pair of every candidate
    logic [NUM_IBAR-1:0][1:0] pairs_q [NUM_PILOTS];

    // each store step writes one bit of the pair for all candidates
    always_ff @(posedge clk_i) begin
        if (reset_ni && wr_en_i) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                pairs_q[wr_idx_i][i][wr_bit_sel_i] <= wr_bits_i[i];
            end
        end
    end

    assign rd_pairs_o = pairs_q[rd_idx_i];

endmodule

`default_nettype wire

// File: hw/pilot_correlator.sv
`timescale 1ns/100ps
`default_nettype none

module pilot_correlator (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic [pbch_pkg::SAMPLE_W-1:0]       sample_i,
    input  logic                                sample_valid_i,
    input  logic                                pilot_en_i,
    input  logic                                clear_i,
    input  logic [pbch_pkg::NUM_IBAR-1:0][1:0]  pairs_i,
    input  logic [pbch_pkg::SEL_W-1:0]          sel_i,
    output logic [pbch_pkg::CORR_W-1:0]         corr_abs_o
);
    import pbch_pkg::*;

    logic [SAMPLE_W-1:0]    sample_q;
    logic [1:0]             demod;
    logic [1:0]             demod_rot;
    // index is {ibar, rotated}; one extra bit so that +128 fits
    logic signed [CORR_W:0] acc_q [2*NUM_IBAR];
    logic signed [CORR_W:0] acc_sel;

    // +2 for two matching bits, 0 for one, -2 for none
    function automatic logic signed [CORR_W:0] pair_score(input logic [1:0] pilot,
                                                         input logic [1:0] rx);
        logic [1:0] diff;
        diff = pilot ^ rx;
        case (diff)
            2'b00:   return (CORR_W+1)'(2);
            2'b11:   return -(CORR_W+1)'(2);
            default: return '0;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_q <= sample_i;
        end
    end

    // hard QPSK decision from the sign bits
    assign demod = {sample_q[SAMPLE_W/2-1], sample_q[SAMPLE_W-1]};
    // same decision after a 90 degree rotation of the input
    assign demod_rot = {~sample_q[SAMPLE_W-1], sample_q[SAMPLE_W/2-1]};

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            for (int i = 0; i < 2*NUM_IBAR; i++) begin
                acc_q[i] <= '0;
            end
        end else if (pilot_en_i) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                acc_q[2*i]   <= acc_q[2*i] + pair_score(pairs_i[i], demod);
                acc_q[2*i+1] <= acc_q[2*i+1] + pair_score(pairs_i[i], demod_rot);
            end
        end
    end

    assign acc_sel = acc_q[sel_i];
    assign corr_abs_o = acc_sel[CORR_W] ? CORR_W'(-acc_sel) : acc_sel[CORR_W-1:0];

    // holds only if the controller clears between symbols
    for (genvar gi = 0; gi < 2*NUM_IBAR; gi++) begin : g_range_chk
        acc_range_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
            (acc_q[gi] >= -ACC_MAX) && (acc_q[gi] <= ACC_MAX));
    end

endmodule

`default_nettype wire

// File: hw/peak_search.sv
`timescale 1ns/100ps
`default_nettype none

module peak_search (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         start_i,
    input  logic [pbch_pkg::CORR_W-1:0]  corr_abs_i,
    output logic [pbch_pkg::SEL_W-1:0]   sel_o,
    output logic                         done_o,
    output logic [pbch_pkg::IBAR_W-1:0]  ibar_o,
    output logic [pbch_pkg::CORR_W-1:0]  peak_o
);
    import pbch_pkg::*;

    logic              busy_q;
    logic [CORR_W-1:0] max_q;
    logic [CORR_W-1:0] max_n;
    logic [IBAR_W-1:0] best_q;
    logic [IBAR_W-1:0] best_n;
    logic              take;

    // strict compare, so the lowest candidate keeps a tie
    assign take = corr_abs_i > max_q;
    assign max_n = take ? corr_abs_i : max_q;
    assign best_n = take ? sel_o[IBAR_W:1] : best_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q <= 1'b0;
            sel_o  <= '0;
            done_o <= 1'b0;
            max_q  <= '0;
            best_q <= '0;
            ibar_o <= '0;
            peak_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                sel_o  <= '0;
                max_q  <= '0;
                best_q <= '0;
            end else if (busy_q) begin
                max_q  <= max_n;
                best_q <= best_n;
                sel_o  <= sel_o + 1'b1;
                if (sel_o == '1) begin
                    // last accumulator, publish the result
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                    ibar_o <= best_n;
                    peak_o <= max_n;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pbch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pbch_ctrl (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    input  logic                           n_id_valid_i,
    input  logic [1:0]                     n_id_lsb_i,
    input  logic                           pbch_start_i,
    input  logic                           sample_valid_i,
    input  logic                           search_done_i,
    output logic                           load_o,
    output logic                           step_o,
    output logic                           wr_en_o,
    output logic [pbch_pkg::PILOT_W-1:0]   wr_idx_o,
    output logic                           wr_bit_sel_o,
    output logic [pbch_pkg::PILOT_W-1:0]   rd_idx_o,
    output logic                           pilot_en_o,
    output logic                           clear_o,
    output logic                           search_start_o,
    output logic                           dmrs_ready_o,
    output logic                           ibar_valid_o
);
    import pbch_pkg::*;

    gen_state_e           gen_q;
    det_state_e           det_q;
    logic [GEN_CNT_W-1:0] gen_cnt_q;
    logic [SC_W-1:0]      sc_cnt_q;
    logic [1:0]           offset_q;

    // pilot generation, restarted by every new cell identity
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            gen_q     <= GEN_IDLE;
            gen_cnt_q <= '0;
            offset_q  <= '0;
        end else if (n_id_valid_i) begin
            gen_q     <= GEN_LOAD;
            gen_cnt_q <= '0;
            offset_q  <= n_id_lsb_i;
        end else begin
            case (gen_q)
                GEN_LOAD: gen_q <= GEN_SKIP;
                GEN_SKIP: begin
                    if (gen_cnt_q == GEN_CNT_W'(GOLD_SKIP - 1)) begin
                        gen_cnt_q <= '0;
                        gen_q     <= GEN_STORE;
                    end else begin
                        gen_cnt_q <= gen_cnt_q + 1'b1;
                    end
                end
                GEN_STORE: begin
                    if (gen_cnt_q == GEN_CNT_W'(STORE_STEPS - 1)) begin
                        gen_q <= GEN_DONE;
                    end else begin
                        gen_cnt_q <= gen_cnt_q + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign load_o = (gen_q == GEN_LOAD);
    assign step_o = (gen_q == GEN_SKIP) || (gen_q == GEN_STORE);
    assign wr_en_o = (gen_q == GEN_STORE);
    // even steps give bit 1 of a pair, odd steps bit 0
    assign wr_idx_o = gen_cnt_q[PILOT_W:1];
    assign wr_bit_sel_o = ~gen_cnt_q[0];
    assign dmrs_ready_o = (gen_q == GEN_DONE);

    // detection; pilot strobe and index line up with the registered sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            det_q          <= DET_IDLE;
            sc_cnt_q       <= '0;
            pilot_en_o     <= 1'b0;
            rd_idx_o       <= '0;
            search_start_o <= 1'b0;
        end else begin
            pilot_en_o     <= 1'b0;
            search_start_o <= 1'b0;
            case (det_q)
                DET_IDLE: begin
                    if (pbch_start_i && dmrs_ready_o) begin
                        det_q    <= DET_ACCUM;
                        sc_cnt_q <= '0;
                    end
                end
                DET_ACCUM: begin
                    if (sample_valid_i) begin
                        pilot_en_o <= (sc_cnt_q[1:0] == offset_q);
                        rd_idx_o   <= sc_cnt_q[SC_W-1:2];
                        sc_cnt_q   <= sc_cnt_q + 1'b1;
                        if (sc_cnt_q == SC_W'(FFT_LEN - 1)) begin
                            det_q          <= DET_SEARCH;
                            search_start_o <= 1'b1;
                        end
                    end
                end
                DET_SEARCH: begin
                    if (search_done_i) begin
                        det_q <= DET_REPORT;
                    end
                end
                default: det_q <= DET_IDLE;
            endcase
        end
    end

    assign ibar_valid_o = (det_q == DET_REPORT);
    // accumulators restart from zero for the next symbol
    assign clear_o = (det_q == DET_REPORT);

    // each search result gives exactly one single-cycle report
    ibar_valid_pulse_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        search_done_i |=> ibar_valid_o ##1 !ibar_valid_o);

endmodule

`default_nettype wire

// File: hw/pbch_ibar_detector.sv
`timescale 1ns/100ps
`default_nettype none

module pbch_ibar_detector (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    input  logic [pbch_pkg::SAMPLE_W-1:0]  sample_i,
    input  logic                           sample_valid_i,
    input  logic                           pbch_start_i,
    input  logic [pbch_pkg::NID_W-1:0]     n_id_i,
    input  logic                           n_id_valid_i,
    output logic                           dmrs_ready_o,
    output logic [pbch_pkg::IBAR_W-1:0]    ibar_o,
    output logic                           ibar_valid_o,
    output logic [pbch_pkg::CORR_W-1:0]    peak_corr_o
);
    import pbch_pkg::*;

    logic                     load;
    logic                     step;
    logic [NUM_IBAR-1:0]      c_bits;
    logic                     wr_en;
    logic [PILOT_W-1:0]       wr_idx;
    logic                     wr_bit_sel;
    logic [PILOT_W-1:0]       rd_idx;
    logic [NUM_IBAR-1:0][1:0] rd_pairs;
    logic                     pilot_en;
    logic                     clear;
    logic [SEL_W-1:0]         sel;
    logic [CORR_W-1:0]        corr_abs;
    logic                     search_start;
    logic                     search_done;

    gold_seq_gen gold_seq_gen_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .load_i       (load),
        .step_i       (step),
        .c_bits_o     (c_bits)
    );

    dmrs_store dmrs_store_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_bit_sel_i (wr_bit_sel),
        .wr_bits_i    (c_bits),
        .rd_idx_i     (rd_idx),
        .rd_pairs_o   (rd_pairs)
    );

    pilot_correlator pilot_correlator_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pilot_en_i     (pilot_en),
        .clear_i        (clear),
        .pairs_i        (rd_pairs),
        .sel_i          (sel),
        .corr_abs_o     (corr_abs)
    );

    peak_search peak_search_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .start_i    (search_start),
        .corr_abs_i (corr_abs),
        .sel_o      (sel),
        .done_o     (search_done),
        .ibar_o     (ibar_o),
        .peak_o     (peak_corr_o)
    );

    pbch_ctrl pbch_ctrl_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_valid_i   (n_id_valid_i),
        .n_id_lsb_i     (n_id_i[1:0]),
        .pbch_start_i   (pbch_start_i),
        .sample_valid_i (sample_valid_i),
        .search_done_i  (search_done),
        .load_o         (load),
        .step_o         (step),
        .wr_en_o        (wr_en),
        .wr_idx_o       (wr_idx),
        .wr_bit_sel_o   (wr_bit_sel),
        .rd_idx_o       (rd_idx),
        .pilot_en_o     (pilot_en),
        .clear_o        (clear),
        .search_start_o (search_start),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_valid_o   (ibar_valid_o)
    );

endmodule

`default_nettype wire

// File: dv/pbch_ibar_detector_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pbch_ibar_detector_tb;
    import pbch_pkg::*;

    localparam int READY_TIMEOUT = 4000;
    localparam int REPORT_TIMEOUT = 200;
    localparam int GATE_WATCH = 150;

    logic                clk_i;
    logic                reset_ni;
    logic [SAMPLE_W-1:0] sample_i;
    logic                sample_valid_i;
    logic                pbch_start_i;
    logic [NID_W-1:0]    n_id_i;
    logic                n_id_valid_i;
    logic                dmrs_ready_o;
    logic [IBAR_W-1:0]   ibar_o;
    logic                ibar_valid_o;
    logic [CORR_W-1:0]   peak_corr_o;

    int                  seed = 47700;
    int                  errors = 0;
    int                  exp_ibar;
    int                  exp_peak;
    logic [1:0]          pilot_tab [NUM_IBAR][NUM_PILOTS];
    logic [SAMPLE_W-1:0] sym [FFT_LEN];

    pbch_ibar_detector pbch_ibar_detector_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_o         (ibar_o),
        .ibar_valid_o   (ibar_valid_o),
        .peak_corr_o    (peak_corr_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    // reference pilots, c(n) = x1(n+Nc) xor x2(n+Nc), pair p = {c(2p), c(2p+1)}
    task automatic build_pilots(input int n_id);
        logic x1 [GOLD_SKIP + 2*NUM_PILOTS + GOLD_N];
        logic x2 [GOLD_SKIP + 2*NUM_PILOTS + GOLD_N];
        int   c_init;
        for (int ib = 0; ib < NUM_IBAR; ib++) begin
            c_init = 2048 * (ib + 1) * (n_id / 4 + 1) + 64 * (ib + 1) + n_id % 4;
            for (int n = 0; n < GOLD_N; n++) begin
                x1[n] = (n == 0);
                x2[n] = c_init[n];
            end
            for (int n = 0; n < GOLD_SKIP + 2*NUM_PILOTS; n++) begin
                x1[n+GOLD_N] = x1[n+3] ^ x1[n];
                x2[n+GOLD_N] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
            end
            for (int p = 0; p < NUM_PILOTS; p++) begin
                pilot_tab[ib][p] = {x1[GOLD_SKIP+2*p] ^ x2[GOLD_SKIP+2*p],
                                    x1[GOLD_SKIP+2*p+1] ^ x2[GOLD_SKIP+2*p+1]};
            end
        end
    endtask

    // pair bit 1 sets a negative real part, bit 0 a negative imaginary part
    task automatic build_symbol(input int n_id, input int ibar, input int rot,
                                input int flips);
        logic [1:0]          pair;
        logic [SAMPLE_W-1:0] rnd;
        logic                sign_re;
        logic                sign_im;
        int                  p;
        for (int k = 0; k < FFT_LEN; k++) begin
            rnd = $random(seed);
            sym[k] = rnd;
            if (k % 4 == n_id % 4) begin
                p = (k - n_id % 4) / 4;
                pair = pilot_tab[ibar][p];
                // inverted pilots spread over the symbol
                if ((p * 37) % NUM_PILOTS < flips) begin
                    pair = ~pair;
                end
                // rotated input is the clean one turned by -90 degrees
                sign_re = (rot != 0) ? pair[0] : pair[1];
                sign_im = (rot != 0) ? ~pair[1] : pair[0];
                sym[k] = {sign_im, rnd[30:16], sign_re, rnd[14:0]};
            end
        end
    endtask

    // +1 per matching bit, -1 otherwise; strict maximum over |corr|, lowest ibar first
    task automatic compute_expected(input int n_id);
        int   acc [NUM_IBAR][2];
        logic d [2][2];
        int   p;
        int   mag;
        for (int c = 0; c < NUM_IBAR; c++) begin
            acc[c][0] = 0;
            acc[c][1] = 0;
        end
        for (int k = n_id % 4; k < FFT_LEN; k += 4) begin
            p = (k - n_id % 4) / 4;
            d[0][1] = sym[k][SAMPLE_W/2-1];
            d[0][0] = sym[k][SAMPLE_W-1];
            d[1][1] = ~sym[k][SAMPLE_W-1];
            d[1][0] = sym[k][SAMPLE_W/2-1];
            for (int c = 0; c < NUM_IBAR; c++) begin
                for (int r = 0; r < 2; r++) begin
                    acc[c][r] += (pilot_tab[c][p][1] == d[r][1]) ? 1 : -1;
                    acc[c][r] += (pilot_tab[c][p][0] == d[r][0]) ? 1 : -1;
                end
            end
        end
        exp_peak = 0;
        exp_ibar = 0;
        for (int c = 0; c < NUM_IBAR; c++) begin
            for (int r = 0; r < 2; r++) begin
                mag = (acc[c][r] < 0) ? -acc[c][r] : acc[c][r];
                if (mag > exp_peak) begin
                    exp_peak = mag;
                    exp_ibar = c;
                end
            end
        end
    endtask

    task automatic send_cell_id(input int n_id);
        @(negedge clk_i);
        n_id_i = NID_W'(n_id);
        n_id_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_valid_i = 1'b0;
        check_value("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (dmrs_ready_o !== 1'b1 && cnt < READY_TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (dmrs_ready_o !== 1'b1) begin
            $display("timeout: dmrs_ready_o did not rise within %0d cycles", READY_TIMEOUT);
            errors++;
        end
    endtask

    // start pulse, then 256 valid samples with random gaps
    task automatic send_symbol();
        int k;
        @(negedge clk_i);
        pbch_start_i = 1'b1;
        @(negedge clk_i);
        pbch_start_i = 1'b0;
        k = 0;
        while (k < FFT_LEN) begin
            sample_valid_i = (($random(seed) & 7) != 0);
            sample_i = sample_valid_i ? sym[k] : $random(seed);
            if (sample_valid_i) begin
                k++;
            end
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
    endtask

    // stops at the first ibar_valid_o or after limit cycles
    task automatic watch_report(input int limit, output bit seen);
        int cnt;
        cnt = 0;
        while (ibar_valid_o !== 1'b1 && cnt < limit) begin
            @(negedge clk_i);
            cnt++;
        end
        seen = (ibar_valid_o === 1'b1);
    endtask

    initial begin
        int    fd;
        int    n_id;
        int    ibar;
        int    rot;
        int    flips;
        int    gate;
        int    test_num;
        int    passed;
        int    err_before;
        bit    seen;
        string line;

        reset_ni = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        pbch_start_i = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        test_num = 0;
        passed = 0;
        repeat (5) @(negedge clk_i);
        reset_ni = 1'b1;
        @(negedge clk_i);
        check_value("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);
        check_value("ibar_valid_o", 32'(ibar_valid_o), 32'd0);
        check_value("ibar_o", 32'(ibar_o), 32'd0);
        check_value("peak_corr_o", 32'(peak_corr_o), 32'd0);

        fd = $fopen("dv/pbch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/pbch_stimulus.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if ($sscanf(line, "%d %d %d %d %d", n_id, ibar, rot, flips, gate) != 5) begin
                    continue;
                end
                test_num++;
                err_before = errors;
                build_pilots(n_id);
                build_symbol(n_id, ibar, rot, flips);
                compute_expected(n_id);
                send_cell_id(n_id);
                if (gate != 0) begin
                    send_symbol();
                    watch_report(GATE_WATCH, seen);
                    if (seen) begin
                        $display("ibar_valid_o pulsed for a symbol sent before dmrs_ready_o");
                        errors++;
                    end
                end
                wait_ready();
                send_symbol();
                watch_report(REPORT_TIMEOUT, seen);
                if (!seen) begin
                    $display("timeout: no ibar_valid_o within %0d cycles", REPORT_TIMEOUT);
                    errors++;
                end else begin
                    check_value("ibar_o", 32'(ibar_o), 32'(exp_ibar));
                    check_value("peak_corr_o", 32'(peak_corr_o), 32'(exp_peak));
                    if (flips == 0) begin
                        check_value("ibar_o", 32'(ibar_o), 32'(ibar));
                        check_value("peak_corr_o", 32'(peak_corr_o), 32'(ACC_MAX));
                    end
                end
                if (errors == err_before) begin
                    passed++;
                end
                $display("test %0d n_id=%0d ibar=%0d rot=%0d flips=%0d gate=%0d: %s", test_num,
                         n_id, ibar, rot, flips, gate, (errors == err_before) ? "ok" : "bad");
            end
            $fclose(fd);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d", test_num, passed,
                 test_num - passed, errors);
        if (errors == 0 && test_num > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/pbch_stimulus.txt
# columns: n_id ibar rot flips gate (decimal)
# rot 1 turns the input by -90 degrees, flips inverts that many pilots, gate 1 starts early
0 0 0 0 0
1 3 0 0 0
2 5 0 0 0
1007 7 0 0 0
501 2 1 0 0
846 6 1 0 0
123 4 0 5 0
123 1 0 20 0
642 0 1 12 0
77 5 0 40 0
310 3 0 0 1
955 6 1 0 1

// File: pbch_ibar.f
hw/pbch_pkg.sv
hw/gold_seq_gen.sv
hw/dmrs_store.sv
hw/pilot_correlator.sv
hw/peak_search.sv
hw/pbch_ctrl.sv
hw/pbch_ibar_detector.sv
dv/pbch_ibar_detector_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log for a failure
verilator --binary --timing --assert -f pbch_ibar.f --top-module pbch_ibar_detector_tb \
    -o pbch_sim > sim.log 2>&1 &&
./obj_dir/pbch_sim >> sim.log 2>&1 &&
! grep -q "SOME TESTS FAILED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
